/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= cpuTb
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir

SIM := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) source/cpu_defines.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* source/aluUnit.sv */
`timescale 1ns/100ps

module aluUnit (
  input  isaPkg::word_t   a,
  input  isaPkg::word_t   b,
  input  ctrlPkg::aluOp_t op,
  output isaPkg::word_t   result,
  output logic            zeroOrLess,
  output logic            positive
);
  import isaPkg::*;
  import ctrlPkg::*;

  // Branch compares look at operand a only
  assign zeroOrLess = $signed(a) <= 0;
  assign positive   = $signed(a) > 0;

  always_comb begin
    case (op)
      ALU_ADD:   result = a + b;
      ALU_AND:   result = a & b;
      ALU_OR:    result = a | b;
      ALU_SLT:   result = word_t'($signed(a) < $signed(b));
      ALU_SLTU:  result = word_t'(a < b);
      ALU_PASSA: result = a;
      // a is the delay slot PC, so this is jump address + 8
      ALU_PC8:   result = a + word_t'(4);
      ALU_LEZ:   result = word_t'(zeroOrLess);
      default:   result = '0;
    endcase
  end

endmodule

/* source/controlDecoder.sv */
`timescale 1ns/100ps

module controlDecoder (
  input  logic           clk,
  input  logic           rstN,
  input  isaPkg::word_t  instr,
  input  logic           aluZeroOrLess,
  input  logic           aluPositive,
  input  logic           pcIsZero,
  input  logic           waitrequest,
  output ctrlPkg::ctrl_t ctrl,
  output logic           active,
  output logic           halted
);
  import isaPkg::*;
  import ctrlPkg::*;

  cpuState_t state;
  cpuState_t nextState;
  opcode_t   opcode;
  funct_t    funct;
  logic      extra;        // Another execute state follows
  logic      takeJump;     // Jump or taken branch in EXEC_1
  logic      branchDelay;  // Next fetch loads PC from the saved target
  logic      runEn;        // Low for the first cycle out of reset

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);
  assign active = runEn && (state != HALTED);
  assign halted = state == HALTED;

  always_comb begin
    ctrl     = '0;
    extra    = 1'b0;
    takeJump = 1'b0;
    case (state)
      FETCH, STALL: begin
        if (runEn && !pcIsZero) begin
          ctrl.memRead = 1'b1;
          ctrl.aluSrcA = SRCA_PC;
          ctrl.aluSrcB = SRCB_FOUR;
          ctrl.aluOp   = ALU_ADD;
          ctrl.pcSrc   = branchDelay;
          ctrl.irWrite = !waitrequest;
          ctrl.pcWrite = !waitrequest;
        end
      end
      DECODE: begin
        // Branch target, or link address for JAL
        ctrl.extSel  = 1'b1;
        ctrl.aluSrcA = SRCA_PC;
        ctrl.aluSrcB = SRCB_BROFF;
        ctrl.aluOp   = (opcode == OP_JAL) ? ALU_PC8 : ALU_ADD;
        ctrl.aluSel  = (opcode == OP_BLEZ) || (opcode == OP_BGTZ);
      end
      EXEC_1, EXEC_2, EXEC_3: begin
        case (opcode)
          OP_RTYPE: begin
            ctrl.aluSrcA = SRCA_REG;
            ctrl.aluSrcB = SRCB_REG;
            case (funct)
              FN_JR: begin
                ctrl.aluOp = ALU_PASSA;
                ctrl.aluSel = 1'b1;
                takeJump = 1'b1;
              end
              FN_JALR: begin
                if (state == EXEC_1) begin
                  ctrl.aluOp = ALU_PASSA;  // Save rs before rd is written
                  ctrl.aluSel = 1'b1;
                  takeJump = 1'b1;
                  extra = 1'b1;
                end else if (state == EXEC_2) begin
                  ctrl.aluSrcA = SRCA_PC;
                  ctrl.aluOp = ALU_PC8;
                  extra = 1'b1;
                end else begin
                  ctrl.regWrite = 1'b1;
                  ctrl.regDst = 1'b1;
                end
              end
              default: begin
                if (funct == FN_AND) ctrl.aluOp = ALU_AND;
                else if (funct == FN_OR) ctrl.aluOp = ALU_OR;
                else ctrl.aluOp = ALU_ADD;
                extra = state == EXEC_1;
                ctrl.regWrite = state == EXEC_2;
                ctrl.regDst = 1'b1;
              end
            endcase
          end
          OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI: begin
            ctrl.extSel  = !((opcode == OP_ANDI) || (opcode == OP_ORI));
            ctrl.aluSrcA = SRCA_REG;
            ctrl.aluSrcB = SRCB_IMM;
            case (opcode)
              OP_SLTI:  ctrl.aluOp = ALU_SLT;
              OP_SLTIU: ctrl.aluOp = ALU_SLTU;
              OP_ANDI:  ctrl.aluOp = ALU_AND;
              OP_ORI:   ctrl.aluOp = ALU_OR;
              default:  ctrl.aluOp = ALU_ADD;
            endcase
            extra = state == EXEC_1;
            ctrl.regWrite = state == EXEC_2;
          end
          OP_LW, OP_LB, OP_SW: begin
            // Address stays on the ALU through the access
            ctrl.extSel  = 1'b1;
            ctrl.aluSrcA = SRCA_REG;
            ctrl.aluSrcB = SRCB_IMM;
            ctrl.aluOp   = ALU_ADD;
            if (state == EXEC_1) begin
              extra = 1'b1;
            end else if (state == EXEC_2) begin
              ctrl.iorD = 1'b1;
              ctrl.memWrite = opcode == OP_SW;
              ctrl.memRead = opcode != OP_SW;
              extra = opcode != OP_SW;
            end else begin
              ctrl.regWrite = 1'b1;
              ctrl.memToReg = 1'b1;
              ctrl.byteLoad = opcode == OP_LB;
            end
          end
          OP_J, OP_JAL: begin
            ctrl.aluSrcA  = SRCA_JUMP;
            ctrl.aluOp    = ALU_PASSA;
            ctrl.aluSel   = 1'b1;
            ctrl.regWrite = opcode == OP_JAL;  // Link value sits in aluOut since DECODE
            ctrl.link     = opcode == OP_JAL;
            takeJump      = 1'b1;
          end
          OP_BLEZ, OP_BGTZ: begin
            ctrl.aluSrcA = SRCA_REG;
            ctrl.aluOp   = ALU_LEZ;
            takeJump = (opcode == OP_BLEZ) ? aluZeroOrLess : aluPositive;
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  always_comb begin
    nextState = state;
    case (state)
      FETCH, STALL: begin
        if (runEn) begin
          if (pcIsZero) nextState = HALTED;
          else if (waitrequest) nextState = STALL;
          else nextState = DECODE;
        end
      end
      DECODE: nextState = EXEC_1;
      EXEC_1: nextState = extra ? EXEC_2 : FETCH;
      EXEC_2: begin
        if (!((ctrl.memRead || ctrl.memWrite) && waitrequest)) begin
          nextState = extra ? EXEC_3 : FETCH;
        end
      end
      EXEC_3: nextState = FETCH;
      default: nextState = HALTED;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state       <= FETCH;
      branchDelay <= 1'b0;
      runEn       <= 1'b0;
    end else begin
      runEn <= 1'b1;
      state <= nextState;
      if (state == EXEC_1) branchDelay <= takeJump;
      else if (ctrl.irWrite) branchDelay <= 1'b0;  // Delay slot fetched
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) !(ctrl.memRead && ctrl.memWrite));

  assert property (@(posedge clk) disable iff (!rstN)
    state inside {FETCH, STALL, DECODE, EXEC_1, EXEC_2, EXEC_3, HALTED});

endmodule

/* source/cpuTop.sv */
`timescale 1ns/100ps

module cpuTop (
  input  logic             clk,
  input  logic             rstN,
  output ctrlPkg::memReq_t memReq,
  input  ctrlPkg::memRsp_t memRsp,
  output logic             active,
  output logic             halted
);
  import isaPkg::*;
  import ctrlPkg::*;

  ctrl_t   ctrl;
  word_t   instr;
  logic    pcIsZero;
  word_t   aluA;
  word_t   aluB;
  aluOp_t  aluOp;
  word_t   aluResult;
  logic    aluZeroOrLess;
  logic    aluPositive;
  regIdx_t rdAddrA;
  regIdx_t rdAddrB;
  word_t   rdDataA;
  word_t   rdDataB;
  logic    wrEn;
  regIdx_t wrAddr;
  word_t   wrData;

  controlDecoder u_decoder (
    .clk(clk), .rstN(rstN), .instr(instr),
    .aluZeroOrLess(aluZeroOrLess), .aluPositive(aluPositive),
    .pcIsZero(pcIsZero), .waitrequest(memRsp.waitrequest),
    .ctrl(ctrl), .active(active), .halted(halted)
  );

  multicycleDatapath u_datapath (
    .clk(clk), .rstN(rstN), .ctrl(ctrl), .instr(instr), .pcIsZero(pcIsZero),
    .memReq(memReq), .memRsp(memRsp), .aluA(aluA), .aluB(aluB), .aluOp(aluOp),
    .aluResult(aluResult), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
    .rdDataA(rdDataA), .rdDataB(rdDataB), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
  );

  aluUnit u_alu (
    .a(aluA), .b(aluB), .op(aluOp), .result(aluResult),
    .zeroOrLess(aluZeroOrLess), .positive(aluPositive)
  );

  regFile u_regs (
    .clk(clk), .rstN(rstN), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
    .rdDataA(rdDataA), .rdDataB(rdDataB), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
  );

endmodule

/* source/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Machine word width in bits
`define DATA_WIDTH 32

// Architectural register count
`define REG_COUNT 32

// First fetch address after reset
`define RESET_VECTOR 32'h100

`endif

/* source/ctrlPkg.sv */
package ctrlPkg;

  typedef enum logic [2:0] {
    FETCH, STALL, DECODE, EXEC_1, EXEC_2, EXEC_3, HALTED
  } cpuState_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_AND, ALU_OR, ALU_SLT, ALU_SLTU, ALU_PASSA, ALU_PC8, ALU_LEZ
  } aluOp_t;

  // ALU operand A sources
  localparam logic [1:0] SRCA_PC   = 2'd0;
  localparam logic [1:0] SRCA_REG  = 2'd1;
  localparam logic [1:0] SRCA_JUMP = 2'd2;

  // ALU operand B sources
  localparam logic [1:0] SRCB_REG   = 2'd0;
  localparam logic [1:0] SRCB_FOUR  = 2'd1;
  localparam logic [1:0] SRCB_IMM   = 2'd2;
  localparam logic [1:0] SRCB_BROFF = 2'd3;

  typedef struct packed {
    logic       extSel;    // 1 sign extend, 0 zero extend
    logic       iorD;      // Address from aluOut instead of PC
    logic [1:0] aluSrcA;
    logic [1:0] aluSrcB;
    aluOp_t     aluOp;
    logic       aluSel;    // Capture ALU result as jump target
    logic       irWrite;
    logic       pcWrite;
    logic       regWrite;
    logic       memToReg;
    logic       regDst;    // rd instead of rt
    logic       link;      // Write r31
    logic       memRead;
    logic       memWrite;
    logic       byteLoad;
    logic       pcSrc;     // Saved target instead of PC + 4
  } ctrl_t;

  typedef struct packed {
    isaPkg::word_t address;
    isaPkg::word_t writedata;
    logic          read;
    logic          write;
  } memReq_t;

  typedef struct packed {
    isaPkg::word_t readdata;
    logic          waitrequest;
  } memRsp_t;

endpackage

/* source/isaPkg.sv */
`include "cpu_defines.svh"

package isaPkg;

  typedef logic [`DATA_WIDTH-1:0] word_t;
  typedef logic [4:0] regIdx_t;

  // Primary opcodes, instr[31:26]
  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000,
    OP_J     = 6'b000010,
    OP_JAL   = 6'b000011,
    OP_BLEZ  = 6'b000110,
    OP_BGTZ  = 6'b000111,
    OP_ADDIU = 6'b001001,
    OP_SLTI  = 6'b001010,
    OP_SLTIU = 6'b001011,
    OP_ANDI  = 6'b001100,
    OP_ORI   = 6'b001101,
    OP_LB    = 6'b100000,
    OP_LW    = 6'b100011,
    OP_SW    = 6'b101011
  } opcode_t;

  // R-type function codes, instr[5:0]
  typedef enum logic [5:0] {
    FN_JR   = 6'b001000,
    FN_JALR = 6'b001001,
    FN_ADDU = 6'b100001,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101
  } funct_t;

endpackage

/* source/multicycleDatapath.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module multicycleDatapath (
  input  logic              clk,
  input  logic              rstN,
  input  ctrlPkg::ctrl_t    ctrl,
  output isaPkg::word_t     instr,
  output logic              pcIsZero,
  output ctrlPkg::memReq_t  memReq,
  input  ctrlPkg::memRsp_t  memRsp,
  output isaPkg::word_t     aluA,
  output isaPkg::word_t     aluB,
  output ctrlPkg::aluOp_t   aluOp,
  input  isaPkg::word_t     aluResult,
  output isaPkg::regIdx_t   rdAddrA,
  output isaPkg::regIdx_t   rdAddrB,
  input  isaPkg::word_t     rdDataA,
  input  isaPkg::word_t     rdDataB,
  output logic              wrEn,
  output isaPkg::regIdx_t   wrAddr,
  output isaPkg::word_t     wrData
);
  import isaPkg::*;
  import ctrlPkg::*;

  word_t pc;
  word_t ir;
  word_t regA;
  word_t regB;
  word_t aluOut;
  word_t target;   // Jump or branch target for the delay slot fetch
  word_t mdr;
  word_t immExt;
  word_t jumpAddr;
  word_t loadByte;
  logic [7:0] byteSel;

  assign instr    = ir;
  assign pcIsZero = pc == '0;
  assign rdAddrA  = ir[25:21];
  assign rdAddrB  = ir[20:16];
  assign aluOp    = ctrl.aluOp;

  assign immExt   = ctrl.extSel ? {{(`DATA_WIDTH-16){ir[15]}}, ir[15:0]}
                                : {{(`DATA_WIDTH-16){1'b0}}, ir[15:0]};
  assign jumpAddr = {pc[31:28], ir[25:0], 2'b00};  // pc already at delay slot

  always_comb begin
    case (ctrl.aluSrcA)
      SRCA_PC:  aluA = pc;
      SRCA_REG: aluA = regA;
      default:  aluA = jumpAddr;
    endcase
    case (ctrl.aluSrcB)
      SRCB_REG:  aluB = regB;
      SRCB_FOUR: aluB = word_t'(4);
      SRCB_IMM:  aluB = immExt;
      default:   aluB = immExt << 2;
    endcase
  end

  assign memReq.address   = ctrl.iorD ? aluOut : pc;
  assign memReq.writedata = regB;
  assign memReq.read      = ctrl.memRead;
  assign memReq.write     = ctrl.memWrite;

  // Little-endian byte lanes
  always_comb begin
    case (aluOut[1:0])
      2'd0:    byteSel = mdr[7:0];
      2'd1:    byteSel = mdr[15:8];
      2'd2:    byteSel = mdr[23:16];
      default: byteSel = mdr[31:24];
    endcase
  end
  assign loadByte = {{(`DATA_WIDTH-8){byteSel[7]}}, byteSel};

  assign wrEn   = ctrl.regWrite;
  assign wrAddr = ctrl.link ? regIdx_t'(31) : (ctrl.regDst ? ir[15:11] : ir[20:16]);
  assign wrData = ctrl.memToReg ? (ctrl.byteLoad ? loadByte : mdr) : aluOut;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) pc <= `RESET_VECTOR;
    else if (ctrl.pcWrite) pc <= ctrl.pcSrc ? target : aluResult;
  end

  always_ff @(posedge clk) begin
    if (ctrl.irWrite) ir <= memRsp.readdata;
    if (ctrl.aluSel) target <= aluResult;
    regA   <= rdDataA;
    regB   <= rdDataB;
    aluOut <= aluResult;
    mdr    <= memRsp.readdata;  // Read data valid when the access completes
  end

endmodule

/* source/regFile.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module regFile (
  input  logic             clk,
  input  logic             rstN,
  input  isaPkg::regIdx_t  rdAddrA,
  input  isaPkg::regIdx_t  rdAddrB,
  output isaPkg::word_t    rdDataA,
  output isaPkg::word_t    rdDataB,
  input  logic             wrEn,
  input  isaPkg::regIdx_t  wrAddr,
  input  isaPkg::word_t    wrData
);
  import isaPkg::*;

  word_t regs [`REG_COUNT];

  assign rdDataA = regs[rdAddrA];
  assign rdDataB = regs[rdAddrB];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) regs[0] <= '0;
    else if (wrEn && (wrAddr != '0)) regs[wrAddr] <= wrData;  // Writes to r0 dropped
  end

  // r0 reads zero on both ports
  assert property (@(posedge clk) disable iff (!rstN)
    ((rdAddrA != '0) || (rdDataA == '0)) && ((rdAddrB != '0) || (rdDataB == '0)));

endmodule

/* sources.f */
+incdir+source
source/isaPkg.sv
source/ctrlPkg.sv
source/controlDecoder.sv
source/aluUnit.sv
source/regFile.sv
source/multicycleDatapath.sv
source/cpuTop.sv
test/tbMemory.sv
test/cpuTb.sv

/* test/cpuTb.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpuTb;
  import isaPkg::*;
  import ctrlPkg::*;

  localparam int    HALT_TIMEOUT = 5000;
  localparam word_t DATA_BASE = 32'h400;

  logic    clk = 1'b0;
  logic    rstN = 1'b0;
  memReq_t memReq;
  memRsp_t memRsp;
  logic    active;
  logic    halted;

  word_t prog [$];
  word_t expAddr [$];
  word_t expData [$];
  word_t storeAddr;      // Next free store slot
  string phase;

  always #4 clk = ~clk;

  cpuTop u_dut (
    .clk(clk), .rstN(rstN), .memReq(memReq), .memRsp(memRsp),
    .active(active), .halted(halted)
  );

  tbMemory u_mem (.clk(clk), .rstN(rstN), .memReq(memReq), .memRsp(memRsp));

  function automatic word_t iType(opcode_t op, regIdx_t rs, regIdx_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t rType(regIdx_t rs, regIdx_t rt, regIdx_t rd, funct_t fn);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t jType(opcode_t op, word_t target);
    return {op, target[27:2]};
  endfunction

  function automatic word_t sext16(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic word_t zext16(logic [15:0] v);
    return {16'h0000, v};
  endfunction

  // Little-endian byte lane, sign extended
  function automatic word_t lbValue(word_t w, int lane);
    logic [7:0] b;
    b = w[8*lane +: 8];
    return {{24{b[7]}}, b};
  endfunction

  function automatic word_t here();
    return `RESET_VECTOR + 32'(4 * prog.size());
  endfunction

  task automatic reportFailure();
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic failWith(string why);
    $display("%s", why);
    reportFailure();
  endtask

  task automatic checkStoreAddr(string ctx, word_t exp, word_t got);
    if (got !== exp) begin
      $display("Error: memReq.address in %s: expected 0x%08h, got 0x%08h", ctx, exp, got);
      reportFailure();
    end
  endtask

  task automatic checkStoreData(string ctx, word_t exp, word_t got);
    if (got !== exp) begin
      $display("Error: memReq.writedata in %s: expected 0x%08h, got 0x%08h", ctx, exp, got);
      reportFailure();
    end
  endtask

  task automatic checkFlags(logic expActive, logic expHalted);
    if (active !== expActive || halted !== expHalted) begin
      $display("Error: active/halted expected 0x%0h/0x%0h, got 0x%0h/0x%0h",
               expActive, expHalted, active, halted);
      reportFailure();
    end
  endtask

  task automatic emit(word_t w);
    prog.push_back(w);
  endtask

  task automatic startProgram();
    prog.delete();
    expAddr.delete();
    expData.delete();
    storeAddr = DATA_BASE;
    u_mem.fillImage();
  endtask

  // SW rt to the next slot, expected to reach memory
  task automatic expectStore(regIdx_t rt, word_t value);
    emit(iType(OP_SW, 5'd0, rt, storeAddr[15:0]));
    expAddr.push_back(storeAddr);
    expData.push_back(value);
    storeAddr = storeAddr + 32'd4;
  endtask

  task automatic checkStores(string name);
    if (u_mem.logAddr.size() != expAddr.size()) begin
      failWith($sformatf("%s (%s): %0d stores seen, %0d expected", name, phase,
                         u_mem.logAddr.size(), expAddr.size()));
    end
    foreach (expAddr[i]) begin
      checkStoreAddr($sformatf("%s store %0d (%s)", name, i, phase), expAddr[i], u_mem.logAddr[i]);
      checkStoreData($sformatf("%s store %0d (%s)", name, i, phase), expData[i], u_mem.logData[i]);
    end
  endtask

  task automatic runProgram(string name);
    int cycles;
    emit(jType(OP_J, 32'h0));  // Jump to zero halts
    emit(32'h0);               // Delay slot
    foreach (prog[i]) u_mem.writeWord(`RESET_VECTOR + 32'(4 * i), prog[i]);
    @(posedge clk);
    #1 rstN = 1'b0;
    repeat (15) @(posedge clk);
    @(negedge clk);
    if (memReq.read || memReq.write) failWith("Memory request raised during reset");
    @(posedge clk);
    #1 rstN = 1'b1;
    repeat (2) @(negedge clk);
    checkFlags(1'b1, 1'b0);
    cycles = 0;
    while (!halted && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) failWith($sformatf("Timeout: %s (%s) never halted", name, phase));
    checkFlags(1'b0, 1'b1);
    repeat (20) @(negedge clk);  // Window for stray stores after the halt
    checkStores(name);
  endtask

  task automatic testImmediates();
    word_t r1;
    startProgram();
    r1 = sext16(16'h8005);
    emit(iType(OP_ADDIU, 5'd0, 5'd1, 16'h8005));
    emit(iType(OP_ORI, 5'd1, 5'd2, 16'hF0F0));
    emit(iType(OP_ANDI, 5'd1, 5'd3, 16'hFF0F));
    emit(iType(OP_SLTI, 5'd1, 5'd4, 16'h0001));
    emit(iType(OP_SLTIU, 5'd1, 5'd5, 16'hFFFF));
    emit(iType(OP_SLTIU, 5'd1, 5'd6, 16'h0001));
    emit(iType(OP_ADDIU, 5'd1, 5'd7, 16'h7FFF));
    emit(iType(OP_SLTI, 5'd0, 5'd8, 16'hFFFF));
    expectStore(5'd1, r1);
    expectStore(5'd2, r1 | zext16(16'hF0F0));
    expectStore(5'd3, r1 & zext16(16'hFF0F));
    expectStore(5'd4, word_t'($signed(r1) < $signed(sext16(16'h0001))));
    expectStore(5'd5, word_t'(r1 < sext16(16'hFFFF)));
    expectStore(5'd6, word_t'(r1 < sext16(16'h0001)));
    expectStore(5'd7, r1 + sext16(16'h7FFF));
    expectStore(5'd8, word_t'($signed(32'h0) < $signed(sext16(16'hFFFF))));
    runProgram("immediates");
  endtask

  task automatic testRegOps();
    word_t a;
    word_t b;
    startProgram();
    a = sext16(16'h7123);
    b = sext16(16'h9F0F);
    emit(iType(OP_ADDIU, 5'd0, 5'd1, 16'h7123));
    emit(iType(OP_ADDIU, 5'd0, 5'd2, 16'h9F0F));
    emit(rType(5'd1, 5'd2, 5'd3, FN_ADDU));
    emit(rType(5'd1, 5'd2, 5'd4, FN_AND));
    emit(rType(5'd1, 5'd2, 5'd5, FN_OR));
    emit(rType(5'd1, 5'd2, 5'd0, FN_ADDU));  // Lost write to r0
    emit(rType(5'd0, 5'd1, 5'd6, FN_OR));
    emit(rType(5'd0, 5'd0, 5'd7, FN_ADDU));
    expectStore(5'd3, a + b);
    expectStore(5'd4, a & b);
    expectStore(5'd5, a | b);
    expectStore(5'd0, 32'h0);
    expectStore(5'd6, a);
    expectStore(5'd7, 32'h0);
    runProgram("register ops");
  endtask

  task automatic testLoads();
    word_t dataWord;
    startProgram();
    dataWord = 32'h80F1_7F22;
    u_mem.writeWord(32'h300, dataWord);
    emit(iType(OP_ADDIU, 5'd0, 5'd6, 16'h0300));
    emit(iType(OP_ADDIU, 5'd0, 5'd8, 16'h0304));
    emit(iType(OP_LW, 5'd0, 5'd1, 16'h0300));
    for (int lane = 0; lane < 4; lane++) emit(iType(OP_LB, 5'd6, regIdx_t'(2 + lane), 16'(lane)));
    emit(iType(OP_LB, 5'd8, 5'd7, 16'hFFFF));  // Negative offset, top byte
    expectStore(5'd1, dataWord);
    for (int lane = 0; lane < 4; lane++) expectStore(regIdx_t'(2 + lane), lbValue(dataWord, lane));
    expectStore(5'd7, lbValue(dataWord, 3));
    runProgram("loads");
  endtask

  task automatic testJumps();
    word_t jalAddr;
    word_t jalrAddr;
    startProgram();
    emit(iType(OP_ADDIU, 5'd0, 5'd1, 16'd1));
    emit(jType(OP_J, here() + 32'd12));
    emit(iType(OP_ADDIU, 5'd0, 5'd2, 16'd2));   // Delay slot
    emit(iType(OP_ADDIU, 5'd0, 5'd1, 16'd99));  // Skipped
    jalAddr = here();
    emit(jType(OP_JAL, here() + 32'd12));
    emit(iType(OP_ADDIU, 5'd0, 5'd3, 16'd3));
    emit(iType(OP_ADDIU, 5'd0, 5'd1, 16'd98));
    emit(iType(OP_ADDIU, 5'd0, 5'd4, 16'(here() + 32'd16)));
    jalrAddr = here();
    emit(rType(5'd4, 5'd0, 5'd5, FN_JALR));
    emit(iType(OP_ADDIU, 5'd0, 5'd6, 16'd6));
    emit(iType(OP_ADDIU, 5'd0, 5'd1, 16'd97));
    emit(iType(OP_ADDIU, 5'd0, 5'd7, 16'(here() + 32'd16)));
    emit(rType(5'd7, 5'd0, 5'd0, FN_JR));
    emit(iType(OP_ADDIU, 5'd0, 5'd8, 16'd8));
    emit(iType(OP_ADDIU, 5'd0, 5'd1, 16'd96));
    expectStore(5'd1, 32'd1);
    expectStore(5'd2, 32'd2);
    expectStore(5'd3, 32'd3);
    expectStore(5'd31, jalAddr + 32'd8);
    expectStore(5'd6, 32'd6);
    expectStore(5'd5, jalrAddr + 32'd8);
    expectStore(5'd8, 32'd8);
    runProgram("jumps");
  endtask

  task automatic testBranches();
    word_t vals [3];
    logic  isBlez;
    logic  taken;
    startProgram();
    vals[0] = sext16(16'hFFFB);
    vals[1] = 32'h0;
    vals[2] = 32'd7;
    emit(iType(OP_ADDIU, 5'd0, 5'd1, 16'hFFFB));
    emit(iType(OP_ADDIU, 5'd0, 5'd2, 16'h0000));
    emit(iType(OP_ADDIU, 5'd0, 5'd3, 16'h0007));
    emit(iType(OP_ADDIU, 5'd0, 5'd10, 16'h5A5A));  // Fall-through marker
    for (int op = 0; op < 2; op++) begin
      for (int r = 0; r < 3; r++) begin
        isBlez = op == 0;
        taken = isBlez ? ($signed(vals[r]) <= 0) : ($signed(vals[r]) > 0);
        emit(iType(isBlez ? OP_BLEZ : OP_BGTZ, regIdx_t'(r + 1), 5'd0, 16'd2));
        expectStore(regIdx_t'(r + 1), vals[r]);  // Delay slot always runs
        if (taken) begin
          emit(iType(OP_SW, 5'd0, 5'd10, storeAddr[15:0]));
          storeAddr = storeAddr + 32'd4;
        end else begin
          expectStore(5'd10, 32'h5A5A);
        end
      end
    end
    runProgram("branches");
  endtask

  initial begin
    for (int pass = 0; pass < 2; pass++) begin
      phase = (pass == 0) ? "no wait" : "random wait";
      u_mem.setMaxWait((pass == 0) ? 32'd0 : 32'd3);
      testImmediates();
      testRegOps();
      testLoads();
      testJumps();
      testBranches();
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

/* test/tbMemory.sv */
`timescale 1ns/100ps

module tbMemory (
  input  logic             clk,
  input  logic             rstN,
  input  ctrlPkg::memReq_t memReq,
  output ctrlPkg::memRsp_t memRsp
);
  import isaPkg::*;
  import ctrlPkg::*;

  localparam int WORDS = 1024;

  word_t       mem [WORDS];
  word_t       image [WORDS];          // Copied into mem while reset is low
  word_t       logAddr [$];
  word_t       logData [$];
  word_t       rngState = 32'h30b4aa80;
  logic [31:0] maxWait = 32'd0;
  logic [31:0] waitCnt = 32'd0;        // Wait cycles left for the current access
  logic [9:0]  wordIdx;

  assign wordIdx            = memReq.address[11:2];
  assign memRsp.readdata    = mem[wordIdx];
  assign memRsp.waitrequest = (memReq.read || memReq.write) && (waitCnt != 32'd0);

  function automatic word_t xorshift(word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Background words differ at every address
  task automatic fillImage();
    for (int i = 0; i < WORDS; i++) begin
      image[i] = 32'hE7E7_0000 ^ word_t'(i << 2);
    end
  endtask

  task automatic writeWord(word_t addr, word_t data);
    image[addr[11:2]] = data;
  endtask

  task automatic setMaxWait(logic [31:0] cycles);
    maxWait = cycles;
  endtask

  always @(posedge clk) begin
    if (!rstN) begin
      mem = image;
      logAddr.delete();
      logData.delete();
      waitCnt <= 32'd0;
    end else if (memReq.read || memReq.write) begin
      if (waitCnt != 32'd0) begin
        waitCnt <= waitCnt - 32'd1;
      end else begin
        if (memReq.write) begin  // Accepted store
          mem[wordIdx] = memReq.writedata;
          logAddr.push_back(memReq.address);
          logData.push_back(memReq.writedata);
        end
        rngState = xorshift(rngState);
        waitCnt <= rngState % (maxWait + 32'd1);  // Stall length of the next access
      end
    end
  end

endmodule
